// ==== bench/leaf_sva.sv ====
`timescale 1ns/1ns

module leaf_sva
    import leaf_pkt_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic resend,
    input pkt_t dout
);

    // Tree output blanked for the whole resend window
    a_resend_zero: assert property (@(posedge clk) disable iff (!arst_n)
        resend |-> dout == '0)
        else $error("dout not zero while resend is high");

    a_no_x: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(dout))
        else $error("dout has unknown bits");

    // One packet in flight at a time
    a_single_vld: assert property (@(posedge clk) disable iff (!arst_n)
        dout.vld |=> !dout.vld)
        else $error("dout vld high on two cycles in a row");

endmodule

bind leaf_i5o4 leaf_sva i_sva (
    .clk    (clk),
    .arst_n (arst_n),
    .resend (resend),
    .dout   (dout_leaf_interface2bft)
);

// ==== bench/leaf_tb.sv ====
`timescale 1ns/1ns

module leaf_tb
    import leaf_pkt_pkg::*, leaf_cfg_pkg::*;
();

    localparam int WAIT_LIMIT = 400;   // Cycles per wait

    logic             clk;
    logic             arst_n;
    pkt_t             din;
    logic [PKT_W-1:0] dout;
    logic             resend;
    logic             ap_start;

    route_t            routes [NUM_OUT];   // Copy of the route table
    logic [ADDR_W-1:0] seq [NUM_OUT];
    word_t             coef;
    pkt_t              exp_q [NUM_OUT][$];
    pkt_t              mon_pkt;
    pkt_t              mon_exp;
    int                mon_hit;
    int                n_chk;
    int                n_err;
    int                n_out;
    int                n_sent;
    int                err_mark;

    leaf_i5o4 i_dut (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    always #20 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic pkt_t expect_pkt(int k, word_t data);
        pkt_t p;
        p.vld     = 1'b1;
        p.leaf    = routes[k-1].leaf;
        p.port    = routes[k-1].port;
        p.addr    = seq[k-1];
        p.payload = data * coef;   // Low 32 bits
        return p;
    endfunction

    function automatic route_t new_route(int i);
        route_t r;
        r.leaf = LEAF_W'($urandom);
        r.port = {2'($urandom), 2'(i)};   // Low bits keep ports distinct
        return r;
    endfunction

    task automatic idle_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_empty(int k);
        int cnt;
        cnt = 0;
        while (exp_q[k-1].size() != 0 && cnt < WAIT_LIMIT) begin
            cnt++;
            @(negedge clk);
        end
        if (exp_q[k-1].size() != 0) begin
            $display("Timeout: stream %0d still owes %0d packets", k, exp_q[k-1].size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    endtask

    task automatic drain_all();
        for (int k = 1; k <= NUM_OUT; k++) begin
            wait_empty(k);
        end
    endtask

    task automatic send_pkt(logic [PORT_W-1:0] port, logic [ADDR_W-1:0] addr, word_t data);
        din.vld     = 1'b1;
        din.leaf    = LEAF_W'($urandom);
        din.port    = port;
        din.addr    = addr;
        din.payload = data;
        @(negedge clk);
        din = '0;
    endtask

    task automatic send_cfg(int idx, route_t r);
        routes[idx] = r;
        send_pkt(CFG_PORT, {5'($urandom), 2'(idx)}, word_t'({23'($urandom), r}));
    endtask

    task automatic set_coef(word_t c);
        drain_all();   // Words in flight keep the old coefficient
        coef = c;
        send_pkt(PORT_W'(NUM_IN), ADDR_W'($urandom), c);
    endtask

    task automatic send_data(int k, word_t data);
        wait_empty(k);   // Full rx buffer would drop a second word
        exp_q[k-1].push_back(expect_pkt(k, data));
        seq[k-1] = seq[k-1] + 1'b1;
        n_sent++;
        send_pkt(PORT_W'(k), ADDR_W'($urandom), data);
    endtask

    task automatic end_test(string name);
        $display("Test %-14s done, %0d errors", name, n_err - err_mark);
        err_mark = n_err;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        mon_pkt = pkt_t'(dout);
        if (arst_n && resend) begin
            check_val("dout under resend", 64'(mon_pkt), 64'(0));
        end
        if (arst_n && mon_pkt.vld) begin
            n_out++;
            mon_hit = -1;
            for (int j = 0; j < NUM_OUT; j++) begin
                if (routes[j].leaf == mon_pkt.leaf && routes[j].port == mon_pkt.port) begin
                    mon_hit = j;
                end
            end
            if (mon_hit < 0) begin
                n_err++;
                $display("Packet to leaf %0h port %0h matches no stream",
                         mon_pkt.leaf, mon_pkt.port);
            end else if (exp_q[mon_hit].size() == 0) begin
                n_err++;
                $display("Stream %0d sent a packet that was never expected", mon_hit + 1);
            end else begin
                mon_exp = exp_q[mon_hit].pop_front();
                check_val($sformatf("dout stream %0d", mon_hit + 1),
                          64'(mon_pkt), 64'(mon_exp));
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        din      = '0;
        resend   = 1'b0;
        ap_start = 1'b0;
        coef     = '0;   // Kernel coefficient is cleared until run
        n_chk    = 0;
        n_err    = 0;
        n_out    = 0;
        n_sent   = 0;
        err_mark = 0;
        for (int i = 0; i < NUM_OUT; i++) begin
            routes[i] = '0;
            seq[i]    = '0;
        end
        void'($urandom(86));
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < NUM_OUT; i++) begin
            send_cfg(i, new_route(i));
        end

        // Words before ap_start wait in rx and leave scaled by zero
        for (int k = 1; k <= NUM_OUT; k++) begin
            send_data(k, word_t'($urandom));
        end
        idle_cycles(20);
        check_val("output count", 64'(n_out), 64'(0));
        ap_start = 1'b1;
        @(negedge clk);
        ap_start = 1'b0;
        set_coef(word_t'($urandom));
        for (int k = 1; k <= NUM_OUT; k++) begin
            send_data(k, word_t'($urandom));
        end
        drain_all();
        end_test("start_gate");

        for (int r = 0; r < 3; r++) begin
            set_coef(word_t'($urandom));
            for (int i = 0; i < NUM_OUT; i++) begin
                send_cfg(i, new_route(i));
            end
            for (int k = 1; k <= NUM_OUT; k++) begin
                send_data(k, word_t'($urandom));
                send_data(k, word_t'($urandom));
            end
        end
        drain_all();
        end_test("coef_reroute");

        // Enough traffic to wrap every sequence count
        for (int n = 0; n < 600; n++) begin
            send_data(1 + int'($urandom % NUM_OUT), word_t'($urandom));
        end
        drain_all();
        end_test("random_seq");

        for (int k = 1; k <= NUM_OUT; k++) begin
            send_data(k, word_t'($urandom));
        end
        resend = 1'b1;
        idle_cycles(20);
        resend = 1'b0;
        drain_all();
        check_val("output count", 64'(n_out), 64'(n_sent));
        end_test("resend");

        for (int p = NUM_IN + 1; p < 2**PORT_W; p++) begin
            send_pkt(PORT_W'(p), ADDR_W'($urandom), word_t'($urandom));
        end
        idle_cycles(20);
        check_val("output count", 64'(n_out), 64'(n_sent));
        for (int k = 1; k <= NUM_OUT; k++) begin
            send_data(k, word_t'($urandom));
        end
        drain_all();
        check_val("output count", 64'(n_out), 64'(n_sent));
        end_test("discard");

        $display("%0d checks, %0d errors, %0d packets received", n_chk, n_err, n_out);
        if (n_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/leaf_cfg_pkg.sv ====
package leaf_cfg_pkg;

    import leaf_pkt_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Leaf configuration and stream counts
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Where one output stream is sent in the tree
    typedef struct packed {
        logic [LEAF_W-1:0] leaf;
        logic [PORT_W-1:0] port;
    } route_t;

    localparam logic [PORT_W-1:0] CFG_PORT = '0;  // Route table writes

    localparam int NUM_IN  = 5;   // Tree to kernel
    localparam int NUM_OUT = 4;   // Kernel to tree

endpackage

// ==== rtl/leaf_i5o4.sv ====
`timescale 1ns/1ns

module leaf_i5o4
    import leaf_pkt_pkg::*, leaf_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic [PKT_W-1:0] din_leaf_bft2interface,
    output logic [PKT_W-1:0] dout_leaf_interface2bft,
    input  logic             resend,
    input  logic             ap_start
);

    pkt_t                       din_pkt;
    pkt_t                       dout_pkt;
    logic                       cfg_we;
    logic [$clog2(NUM_OUT)-1:0] cfg_idx;
    route_t                     cfg_route;
    route_t [NUM_OUT-1:0]       route_table;
    logic                       run;

    leaf_stream_if #(.payload_t(word_t)) in_s  [1:NUM_IN]  ();   // Interface to kernel
    leaf_stream_if #(.payload_t(word_t)) out_s [1:NUM_OUT] ();   // Kernel to interface

    assign din_pkt                 = pkt_t'(din_leaf_bft2interface);
    assign dout_leaf_interface2bft = dout_pkt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tree side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    leaf_rx_demux i_rx (
        .clk       (clk),
        .arst_n    (arst_n),
        .din       (din_pkt),
        .in_s      (in_s),
        .cfg_we    (cfg_we),
        .cfg_idx   (cfg_idx),
        .cfg_route (cfg_route)
    );

    leaf_route_regs i_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_we      (cfg_we),
        .cfg_idx     (cfg_idx),
        .cfg_route   (cfg_route),
        .ap_start    (ap_start),
        .route_table (route_table),
        .run         (run)
    );

    leaf_tx_arbiter i_tx (
        .clk         (clk),
        .arst_n      (arst_n),
        .resend      (resend),
        .route_table (route_table),
        .out_s       (out_s),
        .dout        (dout_pkt)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // User side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    leaf_user_kernel i_kernel (
        .clk    (clk),
        .arst_n (arst_n),
        .run    (run),       // Held in reset until ap_start
        .in_s   (in_s),
        .out_s  (out_s)
    );

endmodule

// ==== rtl/leaf_pkt_pkg.sv ====
package leaf_pkt_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tree packet format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int PKT_W     = 49;
    localparam int PAYLOAD_W = 32;
    localparam int LEAF_W    = 5;    // Destination leaf
    localparam int PORT_W    = 4;    // Port within the leaf
    localparam int ADDR_W    = 7;    // Sequence or entry index

    typedef logic [PAYLOAD_W-1:0] word_t;

    // Field order follows the tree wire format, vld in bit 48
    typedef struct packed {
        logic              vld;
        logic [LEAF_W-1:0] leaf;
        logic [PORT_W-1:0] port;
        logic [ADDR_W-1:0] addr;
        word_t             payload;
    } pkt_t;

endpackage

// ==== rtl/leaf_route_regs.sv ====
`timescale 1ns/1ns

module leaf_route_regs
    import leaf_cfg_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       cfg_we,
    input  logic [$clog2(NUM_OUT)-1:0] cfg_idx,
    input  route_t                     cfg_route,
    input  logic                       ap_start,
    output route_t [NUM_OUT-1:0]       route_table,
    output logic                       run
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Route table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            route_table <= '0;
        end else if (cfg_we) begin
            route_table[cfg_idx] <= cfg_route;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Kernel start
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Sticky, only reset brings the kernel back down
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
        end else if (ap_start) begin
            run <= 1'b1;
        end
    end

endmodule

// ==== rtl/leaf_rx_demux.sv ====
`timescale 1ns/1ns

module leaf_rx_demux
    import leaf_pkt_pkg::*, leaf_cfg_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  pkt_t                       din,
    leaf_stream_if.src                 in_s [1:NUM_IN],
    output logic                       cfg_we,
    output logic [$clog2(NUM_OUT)-1:0] cfg_idx,
    output route_t                     cfg_route
);

    logic is_cfg;

    assign is_cfg = din.vld && (din.port == CFG_PORT);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Configuration writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_we <= 1'b0;
        end else begin
            cfg_we <= is_cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (is_cfg) begin
            cfg_idx   <= din.addr[$clog2(NUM_OUT)-1:0];            // Entry in addr low bits
            cfg_route <= route_t'(din.payload[$bits(route_t)-1:0]);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One-word buffer per input stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar k = 1; k <= NUM_IN; k++) begin : g_in
        logic hit;
        logic load;

        assign hit  = din.vld && (din.port == PORT_W'(k));
        assign load = hit && !in_s[k].vld;   // Full buffer drops the packet

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                in_s[k].vld <= 1'b0;
            end else if (load) begin
                in_s[k].vld <= 1'b1;
            end else if (in_s[k].ack) begin
                in_s[k].vld <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (load) begin
                in_s[k].data <= din.payload;
                in_s[k].addr <= din.addr;
            end
        end
    end

    // Ports above NUM_IN fall through every decode and are lost here

endmodule

// ==== rtl/leaf_stream_if.sv ====
`timescale 1ns/1ns

interface leaf_stream_if
    import leaf_pkt_pkg::*;
#(
    parameter type payload_t = word_t
);

    payload_t          data;
    logic [ADDR_W-1:0] addr;   // Packet addr travels with the word
    logic              vld;    // Held until ack
    logic              ack;    // Single-cycle pulse

    modport src (
        output data,
        output addr,
        output vld,
        input  ack
    );

    modport dst (
        input  data,
        input  addr,
        input  vld,
        output ack
    );

endinterface

// ==== rtl/leaf_tx_arbiter.sv ====
`timescale 1ns/1ns

module leaf_tx_arbiter
    import leaf_pkt_pkg::*, leaf_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 resend,
    input  route_t [NUM_OUT-1:0] route_table,
    leaf_stream_if.dst           out_s [1:NUM_OUT],
    output pkt_t                 dout
);

    localparam int SEL_W = $clog2(NUM_OUT);

    logic [NUM_OUT-1:0] req;
    word_t              data_arr [NUM_OUT];
    logic [NUM_OUT-1:0] ack_vec;
    logic [SEL_W-1:0]   last_q;
    logic [SEL_W-1:0]   sel;
    logic               sel_any;
    logic               grant;
    logic [ADDR_W-1:0]  seq_q [NUM_OUT];
    pkt_t               pkt_q;

    for (genvar k = 1; k <= NUM_OUT; k++) begin : g_port
        assign req[k-1]      = out_s[k].vld;
        assign data_arr[k-1] = out_s[k].data;
        assign out_s[k].ack  = ack_vec[k-1];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Search starts one past the last grant, last grant itself comes last
    always_comb begin
        logic [SEL_W-1:0] cand;
        sel     = last_q;
        sel_any = 1'b0;
        cand    = last_q;
        for (int i = 1; i <= NUM_OUT; i++) begin
            cand = last_q + SEL_W'(i);
            if (!sel_any && req[cand]) begin
                sel     = cand;
                sel_any = 1'b1;
            end
        end
    end

    // One packet in flight, so dout vld never lasts two cycles
    assign grant   = sel_any && !resend && !pkt_q.vld;
    assign ack_vec = grant ? (NUM_OUT'(1) << sel) : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packet register and sequence counts
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_q  <= '0;
            last_q <= SEL_W'(NUM_OUT - 1);   // Stream 1 wins first
            for (int i = 0; i < NUM_OUT; i++) begin
                seq_q[i] <= '0;
            end
        end else if (grant) begin
            pkt_q.vld     <= 1'b1;
            pkt_q.leaf    <= route_table[sel].leaf;
            pkt_q.port    <= route_table[sel].port;
            pkt_q.addr    <= seq_q[sel];
            pkt_q.payload <= data_arr[sel];
            seq_q[sel]    <= seq_q[sel] + 1'b1;   // Wraps at 128
            last_q        <= sel;
        end else if (!resend) begin
            pkt_q <= '0;
        end
    end

    // A packet caught by resend stays in pkt_q and shows once resend drops
    assign dout = resend ? '0 : pkt_q;

endmodule

// ==== rtl/leaf_user_kernel.sv ====
`timescale 1ns/1ns

module leaf_user_kernel
    import leaf_pkt_pkg::*, leaf_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       run,
    leaf_stream_if.dst in_s  [1:NUM_IN],
    leaf_stream_if.src out_s [1:NUM_OUT]
);

    word_t coef_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Coefficient, last input stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in_s[NUM_IN].ack = run && in_s[NUM_IN].vld;   // Always ready once running

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            coef_q <= '0;
        end else if (!run) begin
            coef_q <= '0;
        end else if (in_s[NUM_IN].vld) begin
            coef_q <= in_s[NUM_IN].data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scaling lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar k = 1; k <= NUM_OUT; k++) begin : g_lane
        logic take;

        // Stalls while the output word waits for the arbiter
        assign take        = run && in_s[k].vld && !out_s[k].vld;
        assign in_s[k].ack = take;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                out_s[k].vld <= 1'b0;
            end else if (!run) begin
                out_s[k].vld <= 1'b0;
            end else if (take) begin
                out_s[k].vld <= 1'b1;
            end else if (out_s[k].ack) begin
                out_s[k].vld <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (take) begin
                out_s[k].data <= in_s[k].data * coef_q;   // Low 32 bits kept
                out_s[k].addr <= in_s[k].addr;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build leaf_tb with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module leaf_tb -Mdir "$OBJ" -o leaf_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/leaf_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    exit 0
fi
echo "No pass line found in $LOG"
exit 1

// ==== vlog.f ====
rtl/leaf_pkt_pkg.sv
rtl/leaf_cfg_pkg.sv
rtl/leaf_stream_if.sv
rtl/leaf_rx_demux.sv
rtl/leaf_route_regs.sv
rtl/leaf_tx_arbiter.sv
rtl/leaf_user_kernel.sv
rtl/leaf_i5o4.sv
bench/leaf_sva.sv
bench/leaf_tb.sv
